//--- logic/aluController.sv
`timescale 1ns/1ps
`default_nettype none

module aluController (
        input  mipsCtrlPkg::aluOpT aluOp,
        input  mipsIsaPkg::functT  funct,
        output mipsCtrlPkg::aluFnT aluFn
);
        import mipsIsaPkg::*;
        import mipsCtrlPkg::*;

        logic functKnown;                       // funct is a supported r-type

        always_comb begin
                functKnown = 1'b1;
                case (aluOp)
                        aopAdd:  aluFn = fnAddA;
                        aopSub:  aluFn = fnSubA;
                        aopAnd:  aluFn = fnAndA;
                        aopOr:   aluFn = fnOrA;
                        aopXor:  aluFn = fnXorA;
                        aopSlt:  aluFn = fnSltA;
                        aopSltu: aluFn = fnSltuA;
                        aopFunct: begin
                                case (funct)
                                        fnAdd, fnAddu: aluFn = fnAddA; // overflow ignored
                                        fnSub, fnSubu: aluFn = fnSubA;
                                        fnAnd:         aluFn = fnAndA;
                                        fnOr:          aluFn = fnOrA;
                                        fnXor:         aluFn = fnXorA;
                                        fnNor:         aluFn = fnNorA;
                                        fnSlt:         aluFn = fnSltA;
                                        fnSltu:        aluFn = fnSltuA;
                                        default: begin
                                                aluFn      = fnAddA;
                                                functKnown = 1'b0;
                                        end
                                endcase
                        end
                        default: aluFn = fnAddA;
                endcase
        end

        always_comb begin
                assert (aluOp != aopFunct || functKnown)
                        else $error("unsupported funct %b", funct);
        end

endmodule

`default_nettype wire

//--- logic/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
        input  mipsIsaPkg::wordT   a,
        input  mipsIsaPkg::wordT   b,
        input  mipsCtrlPkg::aluFnT aluFn,
        output mipsIsaPkg::wordT   result,
        output logic               zero
);
        import mipsCtrlPkg::*;

        logic lessSigned;
        logic lessUnsigned;

        assign lessSigned   = $signed(a) < $signed(b);
        assign lessUnsigned = a < b;

        always_comb begin
                case (aluFn)
                        fnAddA:  result = a + b;
                        fnSubA:  result = a - b;
                        fnAndA:  result = a & b;
                        fnOrA:   result = a | b;
                        fnXorA:  result = a ^ b;
                        fnNorA:  result = ~(a | b);
                        fnSltA:  result = {31'b0, lessSigned};
                        fnSltuA: result = {31'b0, lessUnsigned};
                        default: result = '0;
                endcase
        end

        assign zero = (result == '0);           // branch compare flag

endmodule

`default_nettype wire

//--- logic/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
        input  logic             clk,
        input  mipsIsaPkg::wordT addr,
        input  logic             writeEn,
        input  mipsIsaPkg::wordT writeData,
        output mipsIsaPkg::wordT readData
);
        import mipsIsaPkg::*;

        wordT       mem [dataMemWords];
        logic [5:0] wordIdx;

        assign wordIdx = addr[7:2];             // byte address to word

        always_ff @(posedge clk) begin
                if (writeEn) begin
                        mem[wordIdx] <= writeData;
                end
        end

        assign readData = mem[wordIdx];

        ////////////////////////////////////////
        // store address checks
        ////////////////////////////////////////
        assert property (@(posedge clk) writeEn |-> addr[1:0] == 2'b00)
                else $error("unaligned store to %h", addr);
        assert property (@(posedge clk) writeEn |-> addr < dataMemWords * 4)
                else $error("store beyond data memory at %h", addr);

endmodule

`default_nettype wire

//--- logic/mainController.sv
`timescale 1ns/1ps
`default_nettype none

module mainController (
        input  mipsIsaPkg::opcodeT opcode,
        output mipsCtrlPkg::ctrlT  ctrl
);
        import mipsIsaPkg::*;
        import mipsCtrlPkg::*;

        always_comb begin
                ctrl = ctrlNop;                 // unknown opcodes fall through as nop
                case (opcode)
                        opRType: begin
                                ctrl.regDst   = 1'b1;
                                ctrl.memToReg = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.aluOp    = aopFunct;
                        end
                        opAddi, opAddiu: begin  // no overflow trap, so same decode
                                ctrl.aluSource = 1'b1;
                                ctrl.memToReg  = 1'b1;
                                ctrl.regWrite  = 1'b1;
                                ctrl.aluOp     = aopAdd;
                        end
                        opAndi, opOri, opXori: begin
                                ctrl.aluSource  = 1'b1;
                                ctrl.memToReg   = 1'b1;
                                ctrl.regWrite   = 1'b1;
                                ctrl.zeroExtend = 1'b1; // logical ops take unsigned imm
                                if (opcode == opAndi) begin
                                        ctrl.aluOp = aopAnd;
                                end else if (opcode == opOri) begin
                                        ctrl.aluOp = aopOr;
                                end else begin
                                        ctrl.aluOp = aopXor;
                                end
                        end
                        opSlti, opSltiu: begin  // imm sign extended for both
                                ctrl.aluSource = 1'b1;
                                ctrl.memToReg  = 1'b1;
                                ctrl.regWrite  = 1'b1;
                                ctrl.aluOp     = (opcode == opSlti) ? aopSlt : aopSltu;
                        end
                        opLw: begin
                                ctrl.aluSource = 1'b1;
                                ctrl.memToReg  = 1'b0; // take memory word
                                ctrl.regWrite  = 1'b1;
                                ctrl.memRead   = 1'b1;
                                ctrl.aluOp     = aopAdd;
                        end
                        opSw: begin
                                ctrl.aluSource = 1'b1;
                                ctrl.memWrite  = 1'b1;
                                ctrl.aluOp     = aopAdd;
                        end
                        opBeq, opBne: begin     // compare by subtraction
                                ctrl.branch = (opcode == opBeq) ? brEq : brNe;
                                ctrl.aluOp  = aopSub;
                        end
                        default: ;
                endcase
        end

        always_comb begin
                assert (!(ctrl.memRead && ctrl.memWrite))
                        else $error("load and store decoded together, opcode %b", opcode);
        end

endmodule

`default_nettype wire

//--- logic/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
        input  logic               clk,
        input  logic               reset,
        output mipsIsaPkg::wordT   pc,
        input  mipsIsaPkg::wordT   instr,
        output logic               regWriteEn,
        output mipsIsaPkg::regIdxT regWriteAddr,
        output mipsIsaPkg::wordT   regWriteData
);
        import mipsIsaPkg::*;
        import mipsCtrlPkg::*;

        ctrlT        ctrl;
        aluFnT       aluFn;
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      rd;
        logic [15:0] imm;
        wordT        rsData;
        wordT        rtData;
        wordT        immExt;
        wordT        aluB;
        wordT        aluResult;
        logic        aluZero;
        wordT        memReadData;
        logic        memWriteEn;
        logic        branchTaken;
        wordT        pcPlus4;
        wordT        branchTarget;

        ////////////////////////////////////////
        // instruction fields and decode
        ////////////////////////////////////////
        assign rs  = instr[25:21];
        assign rt  = instr[20:16];
        assign rd  = instr[15:11];
        assign imm = instr[15:0];

        mainController mainCtrl (
                .opcode (instr[31:26]),
                .ctrl   (ctrl)
        );

        aluController aluCtrl (
                .aluOp (ctrl.aluOp),
                .funct (instr[5:0]),
                .aluFn (aluFn)
        );

        ////////////////////////////////////////
        // datapath
        ////////////////////////////////////////
        assign immExt = ctrl.zeroExtend ? {16'b0, imm} : {{16{imm[15]}}, imm};
        assign aluB   = ctrl.aluSource ? immExt : rtData;

        registerFile regFile (
                .clk       (clk),
                .reset     (reset),
                .readAddrA (rs),
                .readAddrB (rt),
                .readDataA (rsData),
                .readDataB (rtData),
                .writeEn   (regWriteEn),
                .writeAddr (regWriteAddr),
                .writeData (regWriteData)
        );

        aluUnit alu (
                .a      (rsData),
                .b      (aluB),
                .aluFn  (aluFn),
                .result (aluResult),
                .zero   (aluZero)
        );

        assign memWriteEn = ctrl.memWrite && !reset; // no stores during reset

        dataMemory dataMem (
                .clk       (clk),
                .addr      (aluResult),
                .writeEn   (memWriteEn),
                .writeData (rtData),
                .readData  (memReadData)
        );

        assign regWriteEn   = ctrl.regWrite && !reset;
        assign regWriteAddr = ctrl.regDst ? rd : rt;
        assign regWriteData = ctrl.memToReg ? aluResult : memReadData;

        ////////////////////////////////////////
        // next pc
        ////////////////////////////////////////
        always_comb begin
                case (ctrl.branch)
                        brEq:    branchTaken = aluZero;
                        brNe:    branchTaken = !aluZero;
                        default: branchTaken = 1'b0;
                endcase
        end

        assign pcPlus4      = pc + 32'd4;
        assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00}; // branches sign extend

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc <= '0;
                end else begin
                        pc <= branchTaken ? branchTarget : pcPlus4;
                end
        end

        // a load must hit an aligned word inside data memory
        assert property (@(posedge clk) disable iff (reset)
                ctrl.memRead |-> aluResult[1:0] == 2'b00 && aluResult < dataMemWords * 4)
                else $error("bad load address %h at pc %h", aluResult, pc);

endmodule

`default_nettype wire

//--- logic/mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

        typedef enum logic [1:0] {
                brNone = 2'b00,
                brEq   = 2'b01,                 // taken on zero
                brNe   = 2'b10                  // taken on not zero
        } branchKindT;

        // operation class from the main decoder
        typedef enum logic [2:0] {
                aopAdd   = 3'b000,
                aopSub   = 3'b001,
                aopFunct = 3'b010,              // look at funct field
                aopAnd   = 3'b011,
                aopOr    = 3'b100,
                aopXor   = 3'b101,
                aopSlt   = 3'b110,
                aopSltu  = 3'b111
        } aluOpT;

        typedef enum logic [3:0] {
                fnAddA  = 4'h0,
                fnSubA  = 4'h1,
                fnAndA  = 4'h2,
                fnOrA   = 4'h3,
                fnXorA  = 4'h4,
                fnNorA  = 4'h5,
                fnSltA  = 4'h6,
                fnSltuA = 4'h7
        } aluFnT;

        typedef struct packed {
                logic       regDst;             // write rd, else rt
                logic       aluSource;          // operand b is immediate
                logic       memToReg;           // 1 = alu result, 0 = memory
                logic       regWrite;
                logic       memRead;
                logic       memWrite;
                logic       zeroExtend;         // immediate zero extended
                branchKindT branch;
                aluOpT      aluOp;
        } ctrlT;

        localparam ctrlT ctrlNop = '0;          // everything inactive

endpackage

`default_nettype wire

//--- logic/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

        ////////////////////////////////////////
        // basic widths
        ////////////////////////////////////////
        typedef logic [31:0] wordT;             // data, address or instruction word
        typedef logic [4:0]  regIdxT;           // register index
        typedef logic [5:0]  opcodeT;           // instr[31:26]
        typedef logic [5:0]  functT;            // instr[5:0]

        ////////////////////////////////////////
        // opcodes
        ////////////////////////////////////////
        localparam opcodeT opRType = 6'b000000;
        localparam opcodeT opBeq   = 6'b000100;
        localparam opcodeT opBne   = 6'b000101;
        localparam opcodeT opAddi  = 6'b001000;
        localparam opcodeT opAddiu = 6'b001001;
        localparam opcodeT opSlti  = 6'b001010;
        localparam opcodeT opSltiu = 6'b001011;
        localparam opcodeT opAndi  = 6'b001100;
        localparam opcodeT opOri   = 6'b001101;
        localparam opcodeT opXori  = 6'b001110;
        localparam opcodeT opLw    = 6'b100011;
        localparam opcodeT opSw    = 6'b101011;

        // function field of r-type
        localparam functT fnAdd  = 6'b100000;
        localparam functT fnAddu = 6'b100001;
        localparam functT fnSub  = 6'b100010;
        localparam functT fnSubu = 6'b100011;
        localparam functT fnAnd  = 6'b100100;
        localparam functT fnOr   = 6'b100101;
        localparam functT fnXor  = 6'b100110;
        localparam functT fnNor  = 6'b100111;
        localparam functT fnSlt  = 6'b101010;
        localparam functT fnSltu = 6'b101011;

        localparam int dataMemWords = 64;       // words in data memory

endpackage

`default_nettype wire

//--- logic/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
        input  logic               clk,
        input  logic               reset,
        input  mipsIsaPkg::regIdxT readAddrA,
        input  mipsIsaPkg::regIdxT readAddrB,
        output mipsIsaPkg::wordT   readDataA,
        output mipsIsaPkg::wordT   readDataB,
        input  logic               writeEn,
        input  mipsIsaPkg::regIdxT writeAddr,
        input  mipsIsaPkg::wordT   writeData
);
        import mipsIsaPkg::*;

        wordT regs [1:31];                      // $zero has no storage

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 1; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeEn && writeAddr != '0) begin
                        regs[writeAddr] <= writeData;
                end
        end

        // reads are combinational, no bypass
        assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
        assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the mipsCore testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
        -f vlog.f \
        --top-module mipsCoreTb \
        --Mdir obj_dir \
        -o simv
status=$?
if [ $status -ne 0 ]; then
        echo "verilator build failed with status $status"
        exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
        echo "simulation failed with status $status"
        exit $status
fi

exit 0

//--- verif/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
        import mipsIsaPkg::*;

        typedef struct packed {
                wordT   instr;
                logic   wen;                    // expected regWriteEn
                regIdxT waddr;
                wordT   wdata;
                wordT   nextPc;
        } stepT;

        localparam int randomTests = 32;
        localparam functT  rFuncts [10] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd,
                                            fnOr, fnXor, fnNor, fnSlt, fnSltu};
        localparam int     rKinds  [10] = '{0, 0, 1, 1, 2, 3, 4, 5, 6, 7};
        localparam opcodeT iOps    [7]  = '{opAddi, opAddiu, opAndi, opOri, opXori,
                                            opSlti, opSltiu};
        localparam int     iKinds  [7]  = '{0, 0, 2, 3, 4, 6, 7};

        logic   clk;
        logic   reset;
        wordT   pc;
        wordT   instr;
        logic   regWriteEn;
        regIdxT regWriteAddr;
        wordT   regWriteData;

        stepT   prog [$];                       // indexed by pc / 4
        stepT   row;
        int     idx;
        wordT   rngState;
        int     cycles = 0;
        int     cycleLimit = 0;

        mipsCore dut (
                .clk          (clk),
                .reset        (reset),
                .pc           (pc),
                .instr        (instr),
                .regWriteEn   (regWriteEn),
                .regWriteAddr (regWriteAddr),
                .regWriteData (regWriteData)
        );

        always #2 clk = ~clk;

        ////////////////////////////////////////
        // reporting
        ////////////////////////////////////////
        task automatic stopRun(input string reason);
                $display("%s", reason);
                $display("Result: FAILED");
                $fatal(1, "run stopped");
        endtask

        task automatic checkValue(input string name, input wordT expected, input wordT actual);
                if (actual !== expected) begin
                        stopRun($sformatf("MISMATCH at %0t ns: %s expected %h actual %h",
                                          $time, name, expected, actual));
                end
        endtask

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycleLimit > 0 && cycles >= cycleLimit) begin
                        stopRun($sformatf("timeout: program did not end within %0d cycles",
                                          cycleLimit));
                end
        end

        ////////////////////////////////////////
        // encoding and reference rules
        ////////////////////////////////////////
        function automatic wordT iEnc(input opcodeT op, input regIdxT rs, input regIdxT rt,
                                      input logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic wordT rEnc(input functT fn, input regIdxT rs, input regIdxT rt,
                                      input regIdxT rd);
                return {opRType, rs, rt, rd, 5'b0, fn};
        endfunction

        // kinds 0..7 are add sub and or xor nor slt sltu
        function automatic wordT aluRule(input int kind, input wordT a, input wordT b);
                case (kind)
                        0:       return a + b;
                        1:       return a - b;
                        2:       return a & b;
                        3:       return a | b;
                        4:       return a ^ b;
                        5:       return ~(a | b);
                        6:       return {31'b0, $signed(a) < $signed(b)};
                        default: return {31'b0, a < b};
                endcase
        endfunction

        function automatic wordT xorshift(input wordT s);
                wordT x;
                x = s;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        function wordT nextRandom();
                rngState = xorshift(rngState);
                return rngState;
        endfunction

        ////////////////////////////////////////
        // program table
        ////////////////////////////////////////
        task automatic addStep(input wordT ins, input logic wen, input regIdxT waddr,
                               input wordT wdata, input int skip);
                stepT entry;
                entry.instr  = ins;
                entry.wen    = wen;
                entry.waddr  = waddr;
                entry.wdata  = wdata;
                entry.nextPc = wordT'(4 * (prog.size() + 1 + skip)); // pc + 4 + imm * 4
                prog.push_back(entry);
        endtask

        task automatic buildProgram();
                addStep(iEnc(opAddi, 5'd0, 5'd1, 16'hFFFB), 1'b1, 5'd1, 32'hFFFFFFFB, 0);
                addStep(iEnc(opAddiu, 5'd0, 5'd2, 16'h7FF0), 1'b1, 5'd2, 32'h00007FF0, 0);
                addStep(iEnc(opAndi, 5'd1, 5'd3, 16'h8F0F), 1'b1, 5'd3, 32'h00008F0B, 0);
                addStep(iEnc(opOri, 5'd2, 5'd4, 16'h800F), 1'b1, 5'd4, 32'h0000FFFF, 0);
                addStep(iEnc(opXori, 5'd1, 5'd5, 16'hFFFF), 1'b1, 5'd5, 32'hFFFF0004, 0);
                addStep(iEnc(opSlti, 5'd1, 5'd6, 16'h0001), 1'b1, 5'd6, 32'h1, 0);
                addStep(iEnc(opSltiu, 5'd1, 5'd7, 16'h0001), 1'b1, 5'd7, 32'h0, 0);
                addStep(iEnc(opSltiu, 5'd2, 5'd8, 16'hFFFF), 1'b1, 5'd8, 32'h1, 0);
                addStep(rEnc(fnAdd, 5'd1, 5'd2, 5'd9), 1'b1, 5'd9, 32'h00007FEB, 0);
                addStep(rEnc(fnSub, 5'd2, 5'd1, 5'd10), 1'b1, 5'd10, 32'h00007FF5, 0);
                addStep(rEnc(fnAnd, 5'd1, 5'd4, 5'd11), 1'b1, 5'd11, 32'h0000FFFB, 0);
                addStep(rEnc(fnOr, 5'd3, 5'd5, 5'd12), 1'b1, 5'd12, 32'hFFFF8F0F, 0);
                addStep(rEnc(fnXor, 5'd1, 5'd5, 5'd13), 1'b1, 5'd13, 32'h0000FFFF, 0);
                addStep(rEnc(fnNor, 5'd2, 5'd3, 5'd14), 1'b1, 5'd14, 32'hFFFF0004, 0);
                addStep(rEnc(fnSlt, 5'd1, 5'd5, 5'd15), 1'b1, 5'd15, 32'h0, 0); // both negative
                addStep(rEnc(fnSltu, 5'd5, 5'd1, 5'd16), 1'b1, 5'd16, 32'h1, 0);
                addStep(rEnc(fnAddu, 5'd1, 5'd1, 5'd17), 1'b1, 5'd17, 32'hFFFFFFF6, 0);
                addStep(rEnc(fnSubu, 5'd0, 5'd1, 5'd18), 1'b1, 5'd18, 32'h00000005, 0);
                addStep(iEnc(opSw, 5'd0, 5'd5, 16'd8), 1'b0, 5'd0, 32'h0, 0);
                addStep(iEnc(opSw, 5'd0, 5'd4, 16'd16), 1'b0, 5'd0, 32'h0, 0);
                addStep(iEnc(opLw, 5'd0, 5'd19, 16'd8), 1'b1, 5'd19, 32'hFFFF0004, 0);
                addStep(iEnc(opLw, 5'd0, 5'd20, 16'd16), 1'b1, 5'd20, 32'h0000FFFF, 0);
                addStep(iEnc(opBeq, 5'd1, 5'd2, 16'd5), 1'b0, 5'd0, 32'h0, 0);
                addStep(iEnc(opBeq, 5'd13, 5'd4, 16'd2), 1'b0, 5'd0, 32'h0, 2);
                addStep(iEnc(opAddi, 5'd0, 5'd21, 16'd1), 1'b1, 5'd21, 32'h1, 0); // skipped
                addStep(iEnc(opAddi, 5'd0, 5'd21, 16'd2), 1'b1, 5'd21, 32'h2, 0); // skipped
                addStep(iEnc(opBne, 5'd1, 5'd1, 16'd3), 1'b0, 5'd0, 32'h0, 0);
                addStep(iEnc(opBne, 5'd1, 5'd2, 16'd2), 1'b0, 5'd0, 32'h0, 2);
                addStep(iEnc(opAddi, 5'd0, 5'd21, 16'd3), 1'b1, 5'd21, 32'h3, 0); // skipped
                addStep(iEnc(opAddi, 5'd0, 5'd21, 16'd4), 1'b1, 5'd21, 32'h4, 0); // skipped
                addStep(iEnc(opBeq, 5'd0, 5'd0, 16'd2), 1'b0, 5'd0, 32'h0, 2);
                addStep(iEnc(opBeq, 5'd0, 5'd0, 16'd2), 1'b0, 5'd0, 32'h0, 2);
                addStep(iEnc(opAddi, 5'd0, 5'd21, 16'd5), 1'b1, 5'd21, 32'h5, 0); // skipped
                addStep(iEnc(opBeq, 5'd0, 5'd0, 16'hFFFD), 1'b0, 5'd0, 32'h0, -3); // backward
                addStep(iEnc(opAddi, 5'd0, 5'd0, 16'h1234), 1'b1, 5'd0, 32'h00001234, 0);
                addStep(32'hFC000000, 1'b0, 5'd0, 32'h0, 0); // undefined opcode
                addStep(rEnc(fnAddu, 5'd0, 5'd4, 5'd22), 1'b1, 5'd22, 32'h0000FFFF, 0);
        endtask

        task automatic loadOperand(input regIdxT dst, input wordT r, output wordT value);
                wordT high;
                high = {{16{r[31]}}, r[31:16]};
                addStep(iEnc(opAddi, 5'd0, dst, r[31:16]), 1'b1, dst, high, 0);
                value = high | {16'b0, r[15:0]};
                addStep(iEnc(opOri, dst, dst, r[15:0]), 1'b1, dst, value, 0);
        endtask

        task automatic addRandomTest();
                wordT r;
                wordT opA;
                wordT opB;
                wordT immExt;
                int   sel;
                int   kind;
                loadOperand(5'd24, nextRandom(), opA);
                loadOperand(5'd25, nextRandom(), opB);
                r = nextRandom();
                sel = int'(r % 32'd17);
                if (sel < 10) begin
                        addStep(rEnc(rFuncts[sel], 5'd24, 5'd25, 5'd26), 1'b1, 5'd26,
                                aluRule(rKinds[sel], opA, opB), 0);
                end else begin
                        kind = iKinds[sel - 10];
                        if (kind >= 2 && kind <= 4) begin
                                immExt = {16'b0, r[31:16]}; // andi ori xori
                        end else begin
                                immExt = {{16{r[31]}}, r[31:16]};
                        end
                        addStep(iEnc(iOps[sel - 10], 5'd24, 5'd26, r[31:16]), 1'b1, 5'd26,
                                aluRule(kind, opA, immExt), 0);
                end
        endtask

        ////////////////////////////////////////
        // run
        ////////////////////////////////////////
        initial begin
                clk = 1'b0;
                reset = 1'b1;
                instr = rEnc(fnOr, 5'd0, 5'd0, 5'd0); // harmless nop
                rngState = 32'd16540;
                buildProgram();
                for (int t = 0; t < randomTests; t++) begin
                        addRandomTest();
                end
                cycleLimit = 2 * prog.size() + randomTests + 20;

                repeat (3) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;

                while (pc < wordT'(4 * prog.size())) begin
                        idx = int'(pc >> 2);
                        row = prog[idx];
                        instr = row.instr;
                        #1;                     // outputs settle before the edge
                        checkValue("regWriteEn", 32'(row.wen), 32'(regWriteEn));
                        if (row.wen) begin
                                checkValue("regWriteAddr", 32'(row.waddr), 32'(regWriteAddr));
                                checkValue("regWriteData", row.wdata, regWriteData);
                        end
                        @(negedge clk);
                        checkValue("pc", row.nextPc, pc);
                end
                $display("Result: PASSED");
                $finish;
        end

endmodule

`default_nettype wire

//--- vlog.f
logic/mipsIsaPkg.sv
logic/mipsCtrlPkg.sv
logic/mainController.sv
logic/aluController.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/dataMemory.sv
logic/mipsCore.sv
verif/mipsCoreTb.sv
